/* src.f */
+incdir+.
icache_pkg.sv
icache_if.sv
icache_ways.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_icache --Mdir "$OBJ" -o sim_icache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_icache" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

/* tb_icache_model.svh */
`ifndef TB_ICACHE_MODEL_SVH
`define TB_ICACHE_MODEL_SVH

// directory model of valid bits, tags and tree bits per set
logic [NUM_WAYS-1:0] mdl_valid [NUM_SETS];
tag_t                mdl_tag   [NUM_SETS][NUM_WAYS];
plru_t               mdl_plru  [NUM_SETS];

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Test failed");
	$fatal(1, "run stopped at first error");
endtask

task automatic check_value(input string name, input logic [127:0] got, input logic [127:0] exp);
	if (got !== exp) begin
		abort_run($sformatf("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp));
	end
endtask

task automatic clear_model();
	for (int s = 0; s < NUM_SETS; s++) begin
		mdl_valid[s] = '0;   // cache starts empty
		mdl_plru[s]  = '0;
	end
endtask

// bit 0 names the half due for replacement, bit 1 / bit 2 the way inside it
function automatic way_t lru_victim(plru_t p);
	if (!p[0]) begin
		return p[1] ? way_t'(1) : way_t'(0);
	end
	return p[2] ? way_t'(3) : way_t'(2);
endfunction

// after using w point at the other half and at w's sibling
function automatic plru_t touch_way(plru_t p, way_t w);
	plru_t n;
	n = p;
	if (w < way_t'(2)) begin
		n[0] = 1'b1;
		n[1] = (w == way_t'(0));
	end else begin
		n[0] = 1'b0;
		n[2] = (w == way_t'(2));
	end
	return n;
endfunction

// predicts hit or miss, picks the victim on a miss, then updates the model
task automatic predict_access(input addr_t a, output logic hit);
	index_t s;
	tag_t   t;
	way_t   way;
	int     free_way;
	s        = a[INDEX_LSB +: $bits(index_t)];
	t        = a[TAG_LSB +: $bits(tag_t)];
	hit      = 1'b0;
	way      = '0;
	free_way = -1;
	for (int w = NUM_WAYS - 1; w >= 0; w--) begin
		if (mdl_valid[s][w] && mdl_tag[s][w] == t) begin
			hit = 1'b1;
			way = way_t'(w);
		end
		if (!mdl_valid[s][w]) free_way = w;   // ends on the lowest free one
	end
	if (!hit) begin
		way = (free_way >= 0) ? way_t'(free_way) : lru_victim(mdl_plru[s]);
		mdl_tag[s][way]   = t;
		mdl_valid[s][way] = 1'b1;
	end
	mdl_plru[s] = touch_way(mdl_plru[s], way);   // refill counts via the hit after it
endtask

`endif

/* tb_icache.sv */
`default_nettype none

module tb_icache;
	import icache_pkg::*;

	localparam int    CLK_PERIOD   = 4;
	localparam int    RST_CYCLES   = 4;
	localparam int    NUM_REQS     = 400;
	localparam int    SEED         = 32'h422c;
	localparam word_t MEM_KEY      = 32'h5a3c_96e1;   // scrambles memory words
	localparam int    WATCH_CYCLES = NUM_REQS * (int'(LINE_WORDS) * 5 + 10) + RST_CYCLES + 20;

	logic   clk = 1'b0;
	logic   i_rst_n;
	logic   i_req;
	addr_t  i_addr;
	logic   o_ready;
	logic   o_data_ok;
	group_t o_data;
	logic   o_bus_as;
	addr_t  o_bus_addr;
	logic   i_bus_ready = 1'b0;
	word_t  i_bus_data  = '0;

	int     accepted   = 0;      // requests taken by the DUT
	int     ok_count   = 0;      // o_data_ok pulses seen
	logic   ok_prev    = 1'b0;
	int     strobe_cnt = 0;      // strobes in the current refill
	int     gap        = 0;      // idle cycles before next strobe
	logic   bus_as_q   = 1'b0;   // o_bus_as during the last rising edge

	index_t set_pool [3] = '{8'h00, 8'h5a, 8'hff};
	tag_t   tag_pool [6] = '{18'h00000, 18'h00001, 18'h2a5c3, 18'h3ffff, 18'h01000, 18'h15555};

	`include "tb_icache_model.svh"

	icache_top dut0 (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_req       (i_req),
		.i_addr      (i_addr),
		.o_ready     (o_ready),
		.o_data_ok   (o_data_ok),
		.o_data      (o_data),
		.o_bus_as    (o_bus_as),
		.o_bus_addr  (o_bus_addr),
		.i_bus_ready (i_bus_ready),
		.i_bus_data  (i_bus_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic word_t mem_word(addr_t a);
		return word_t'(a >> 2) ^ MEM_KEY;   // word address xor key
	endfunction

	function automatic group_t expect_group(addr_t a);
		group_t g;
		addr_t  base;
		base = a & 32'hffff_fff0;   // first word of the group
		for (int k = 0; k < int'(GROUP_WORDS); k++) begin
			g[k*$bits(word_t) +: $bits(word_t)] = mem_word(base + addr_t'(k * 4));
		end
		return g;
	endfunction

	function automatic addr_t make_addr(index_t s, tag_t t);
		addr_t a;
		a = $urandom;   // random group, word and byte bits
		a[INDEX_LSB +: $bits(index_t)] = s;
		a[TAG_LSB +: $bits(tag_t)]     = t;
		return a;
	endfunction

	// bus memory with one word per strobe, random gaps and stray strobes while idle
	always @(negedge clk) begin
		if (!i_rst_n) begin
			i_bus_ready = 1'b0;
			strobe_cnt  = 0;
			bus_as_q    = 1'b0;
		end else begin
			if (bus_as_q && i_bus_ready) strobe_cnt = strobe_cnt + 1;
			if (bus_as_q && !o_bus_as) begin
				check_value("refill strobes", 128'(strobe_cnt), 128'(LINE_WORDS));
				strobe_cnt = 0;
			end else if (o_bus_as && strobe_cnt == int'(LINE_WORDS)) begin
				abort_run("o_bus_as still high after the last word of the line");
			end
			if (o_bus_as && strobe_cnt < int'(LINE_WORDS)) begin
				if (gap == 0) begin
					i_bus_ready = 1'b1;
					i_bus_data  = mem_word(o_bus_addr + addr_t'(strobe_cnt * 4));
					gap         = $urandom_range(3, 0);
				end else begin
					i_bus_ready = 1'b0;
					i_bus_data  = $urandom;
					gap         = gap - 1;
				end
			end else begin
				i_bus_ready = ($urandom_range(7, 0) == 0);   // ignored by the DUT
				i_bus_data  = $urandom;
			end
			bus_as_q = o_bus_as;
		end
	end

	always @(negedge clk) begin
		if (i_rst_n && o_data_ok) begin
			ok_count = ok_count + 1;
			if (ok_prev) abort_run("o_data_ok held high for two cycles");
		end
		ok_prev = o_data_ok;
	end

	initial begin
		#(CLK_PERIOD * WATCH_CYCLES);
		abort_run("watchdog expired before all requests completed");
	end

	// one fetch, junk requests while busy, then compare with the model
	task automatic run_request(input addr_t a);
		logic exp_hit;
		int   wait_cyc;
		logic saw_as;
		check_value("o_ready", 128'(o_ready), 128'(1));
		predict_access(a, exp_hit);
		i_req    = 1'b1;
		i_addr   = a;
		accepted = accepted + 1;
		wait_cyc = 0;
		saw_as   = 1'b0;
		@(negedge clk);
		while (!o_data_ok) begin
			check_value("o_ready", 128'(o_ready), 128'(0));
			if (o_bus_as && !saw_as) begin
				saw_as = 1'b1;
				check_value("o_bus_addr", 128'(o_bus_addr), 128'(a & 32'hffff_ffc0));
			end
			i_req    = ($urandom_range(3, 0) == 0);
			i_addr   = $urandom;
			wait_cyc = wait_cyc + 1;
			@(negedge clk);
		end
		i_req = 1'b0;
		check_value("o_ready", 128'(o_ready), 128'(1));
		check_value("o_bus_as", 128'(o_bus_as), 128'(0));
		check_value("refill seen", 128'(saw_as), 128'(!exp_hit));
		if (exp_hit) check_value("hit latency", 128'(wait_cyc), 128'(2));
		check_value("o_data", 128'(o_data), 128'(expect_group(a)));
	endtask

	initial begin
		int order [5];
		int pick;
		int tmp;
		int si;
		int ti;
		void'($urandom(SEED));
		i_rst_n = 1'b0;
		i_req   = 1'b0;
		i_addr  = '0;
		clear_model();
		repeat (RST_CYCLES) @(negedge clk);
		i_rst_n = 1'b1;
		@(negedge clk);
		check_value("o_ready", 128'(o_ready), 128'(1));
		check_value("o_bus_as", 128'(o_bus_as), 128'(0));
		check_value("o_data_ok", 128'(o_data_ok), 128'(0));
		// five shuffled tags into one set fill all ways and then evict
		for (int i = 0; i < 5; i++) begin
			order[i] = i;
		end
		for (int i = 4; i > 0; i--) begin
			pick        = $urandom_range(i, 0);
			tmp         = order[i];
			order[i]    = order[pick];
			order[pick] = tmp;
		end
		for (int i = 0; i < 5; i++) begin
			run_request(make_addr(set_pool[0], tag_pool[order[i]]));
		end
		for (int n = 5; n < NUM_REQS; n++) begin
			if ($urandom_range(3, 0) == 0) repeat (2) @(negedge clk);
			si = $urandom_range(2, 0);
			ti = $urandom_range(5, 0);
			run_request(make_addr(set_pool[si], tag_pool[ti]));
		end
		repeat (4) @(negedge clk);
		check_value("o_data_ok count", 128'(ok_count), 128'(accepted));
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* icache_top.sv */
`default_nettype none

module icache_top (
	input  wire logic                clk,
	input  wire logic                i_rst_n,
	// fetch side
	input  wire logic                i_req,
	input  wire icache_pkg::addr_t   i_addr,
	output logic                     o_ready,
	output logic                     o_data_ok,
	output icache_pkg::group_t       o_data,
	// bus side
	output logic                     o_bus_as,
	output icache_pkg::addr_t        o_bus_addr,
	input  wire logic                i_bus_ready,
	input  wire icache_pkg::word_t   i_bus_data
);
	import icache_pkg::*;

	// lookup path between controller and arrays
	logic                         rd_en;
	index_t                       rd_index;
	tag_t  [NUM_WAYS-1:0]         rd_tags;
	logic  [NUM_WAYS-1:0]         rd_valid;
	line_t [NUM_WAYS-1:0]         rd_lines;

	miss_req_if miss_bus ();   // ctrl -> refill
	refill_if   fill_bus ();   // refill -> ways

	icache_ctrl u_ctrl (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_req      (i_req),
		.i_addr     (i_addr),
		.o_ready    (o_ready),
		.o_data_ok  (o_data_ok),
		.o_data     (o_data),
		.o_rd_en    (rd_en),
		.o_rd_index (rd_index),
		.i_tags     (rd_tags),
		.i_valid    (rd_valid),
		.i_lines    (rd_lines),
		.o_miss     (miss_bus.ctrl)
	);

	icache_ways u_ways (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_fill     (fill_bus.ways),
		.i_rd_en    (rd_en),
		.i_rd_index (rd_index),
		.o_tags     (rd_tags),
		.o_valid    (rd_valid),
		.o_lines    (rd_lines)
	);

	icache_refill u_refill (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_miss      (miss_bus.refill),
		.o_fill      (fill_bus.refill),
		.o_bus_as    (o_bus_as),
		.o_bus_addr  (o_bus_addr),
		.i_bus_ready (i_bus_ready),
		.i_bus_data  (i_bus_data)
	);

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`default_nettype none

module icache_ctrl (
	input  wire logic                                       clk,
	input  wire logic                                       i_rst_n,
	input  wire logic                                       i_req,
	input  wire icache_pkg::addr_t                          i_addr,
	output logic                                            o_ready,
	output logic                                            o_data_ok,
	output icache_pkg::group_t                              o_data,
	output logic                                            o_rd_en,
	output icache_pkg::index_t                              o_rd_index,
	input  wire icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] i_tags,
	input  wire logic              [icache_pkg::NUM_WAYS-1:0] i_valid,
	input  wire icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] i_lines,
	miss_req_if.ctrl                                        o_miss
);
	import icache_pkg::*;

	ctrl_state_t state_q;
	addr_t       req_addr_q;            // request in flight
	logic        cmp_vld_q;             // array read-out valid this cycle
	logic        start_q;
	way_t        victim_q;
	plru_t       plru_q [NUM_SETS];     // tree bits per set

	tag_t                req_tag;
	index_t              req_index;
	group_sel_t          grp_sel;
	logic [NUM_WAYS-1:0] hit_vec;
	logic                hit;
	way_t                hit_way;
	way_t                victim;
	way_t                victim_lru;
	plru_t               plru_cur;
	plru_t               plru_nxt;
	line_t               hit_line;
	group_t              hit_group;

	assign req_tag   = req_addr_q[TAG_LSB +: $bits(tag_t)];
	assign req_index = req_addr_q[INDEX_LSB +: $bits(index_t)];
	assign grp_sel   = req_addr_q[GROUP_LSB +: $bits(group_sel_t)];
	assign plru_cur  = plru_q[req_index];

	// tag compare on all ways
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
		assign hit_vec[w] = i_valid[w] && (i_tags[w] == req_tag);
	end

	// hit way, victim choice and next tree state
	always_comb begin
		hit     = |hit_vec;
		hit_way = '0;
		victim  = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (hit_vec[w]) begin
				hit_way = way_t'(w);
			end
		end
		// bit 0 picks the half, bit 1 or 2 the way inside it
		victim_lru = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};
		victim     = victim_lru;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (!i_valid[w]) begin
				victim = way_t'(w);   // lowest invalid way wins
			end
		end
		// point away from the way just used
		plru_nxt    = plru_cur;
		plru_nxt[0] = ~hit_way[1];
		if (!hit_way[1]) begin
			plru_nxt[1] = ~hit_way[0];
		end else begin
			plru_nxt[2] = ~hit_way[0];
		end
	end

	assign hit_line  = i_lines[hit_way];
	assign hit_group = hit_line[grp_sel*$bits(group_t) +: $bits(group_t)];

	// request / miss state machine
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q   <= IDLE;
			o_rd_en   <= 1'b0;
			cmp_vld_q <= 1'b0;
			o_data_ok <= 1'b0;
			start_q   <= 1'b0;
		end else begin
			o_data_ok <= 1'b0;   // pulses
			start_q   <= 1'b0;
			case (state_q)
				IDLE: begin
					if (i_req) begin
						o_rd_en <= 1'b1;
						state_q <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (o_rd_en) begin
						o_rd_en   <= 1'b0;   // arrays read at this edge
						cmp_vld_q <= 1'b1;
					end else if (cmp_vld_q) begin
						cmp_vld_q <= 1'b0;
						if (hit) begin
							o_data_ok <= 1'b1;
							state_q   <= IDLE;
						end else begin
							start_q <= 1'b1;
							state_q <= MISS;
						end
					end
				end
				MISS: begin
					if (o_miss.done) begin
						o_rd_en <= 1'b1;   // reread the fresh line
						state_q <= LOOKUP;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// request address, returned group, victim
	always_ff @(posedge clk) begin
		if (state_q == IDLE && i_req) begin
			req_addr_q <= i_addr;
		end
		if (state_q == LOOKUP && cmp_vld_q) begin
			o_data   <= hit_group;
			victim_q <= victim;
		end
	end

	// pseudo-LRU bits only move on a hit
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				plru_q[s] <= '0;
			end
		end else if (state_q == LOOKUP && cmp_vld_q && hit) begin
			plru_q[req_index] <= plru_nxt;
		end
	end

	assign o_ready          = (state_q == IDLE);
	assign o_rd_index       = req_index;
	assign o_miss.start     = start_q;
	assign o_miss.line_addr = req_addr_q;
	assign o_miss.way       = victim_q;

	// refill reports done only while the controller waits in MISS
	a_done_in_miss : assert property (
		@(posedge clk) disable iff (!i_rst_n)
		o_miss.done |-> (state_q == MISS)
	) else $error("refill done outside a miss");

endmodule

`default_nettype wire

/* icache_refill.sv */
`default_nettype none

module icache_refill (
	input  wire logic                clk,
	input  wire logic                i_rst_n,
	miss_req_if.refill               i_miss,
	refill_if.refill                 o_fill,
	output logic                     o_bus_as,
	output icache_pkg::addr_t        o_bus_addr,
	input  wire logic                i_bus_ready,
	input  wire icache_pkg::word_t   i_bus_data
);
	import icache_pkg::*;

	word_sel_t cnt_q;        // next word to arrive
	way_t      way_q;        // latched victim
	logic      line_we_q;    // cycle after the last word
	logic      done_q;
	logic      busy;         // any refill phase still running
	logic      last_word;

	assign last_word = (cnt_q == word_sel_t'(LINE_WORDS - 1));
	assign busy      = o_bus_as | line_we_q | done_q;

	// control flops
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_as  <= 1'b0;
			cnt_q     <= '0;
			line_we_q <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			line_we_q <= 1'b0;
			done_q    <= line_we_q;   // done one cycle after the tag write
			if (i_miss.start) begin
				o_bus_as <= 1'b1;
				cnt_q    <= '0;
			end else if (o_bus_as && i_bus_ready) begin
				cnt_q <= cnt_q + 1'b1;   // wraps to 0 after word 15
				if (last_word) begin
					o_bus_as  <= 1'b0;
					line_we_q <= 1'b1;
				end
			end
		end
	end

	// line base and victim, held for the whole refill
	always_ff @(posedge clk) begin
		if (i_miss.start) begin
			o_bus_addr <= {i_miss.line_addr[WORD_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
			way_q      <= i_miss.way;
		end
	end

	// invalidate goes out with start itself, so the victim is clear
	// by the edge at which o_bus_as rises
	assign o_fill.invalidate = i_miss.start;
	assign o_fill.way        = i_miss.start ? i_miss.way : way_q;
	assign o_fill.index      = i_miss.start ? i_miss.line_addr[INDEX_LSB +: $bits(index_t)]
	                                        : o_bus_addr[INDEX_LSB +: $bits(index_t)];
	assign o_fill.tag        = o_bus_addr[TAG_LSB +: $bits(tag_t)];
	assign o_fill.word_sel   = cnt_q;
	assign o_fill.data       = i_bus_data;
	assign o_fill.word_we    = o_bus_as & i_bus_ready;   // strobes outside as are dropped
	assign o_fill.line_we    = line_we_q;
	assign i_miss.done       = done_q;

	// controller waits for done before it can miss again
	a_start_idle : assert property (
		@(posedge clk) disable iff (!i_rst_n)
		i_miss.start |-> !busy
	) else $error("miss start while refill busy");

endmodule

`default_nettype wire

/* icache_ways.sv */
`default_nettype none

module icache_ways (
	input  wire logic                                        clk,
	input  wire logic                                        i_rst_n,
	refill_if.ways                                           i_fill,
	input  wire logic                                        i_rd_en,
	input  wire icache_pkg::index_t                          i_rd_index,
	output icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0]     o_tags,
	output logic              [icache_pkg::NUM_WAYS-1:0]     o_valid,
	output icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0]     o_lines
);
	import icache_pkg::*;

	// one copy of the storage per way
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		tag_t                tag_mem  [NUM_SETS];   // tag array
		line_t               data_mem [NUM_SETS];   // data array, one line per set
		logic [NUM_SETS-1:0] valid_q;               // valid flops
		logic                sel;                   // refill targets this way
		tag_t                tag_rd_q;
		line_t               line_rd_q;
		logic                valid_rd_q;

		assign sel = (i_fill.way == way_t'(w));

		// word writes during refill, tag once the line is complete
		always_ff @(posedge clk) begin
			if (sel && i_fill.word_we) begin
				data_mem[i_fill.index][i_fill.word_sel*WORD_W +: WORD_W] <= i_fill.data;
			end
			if (sel && i_fill.line_we) begin
				tag_mem[i_fill.index] <= i_fill.tag;
			end
		end

		// synchronous read port, result one cycle after rd_en
		always_ff @(posedge clk) begin
			if (i_rd_en) begin
				tag_rd_q   <= tag_mem[i_rd_index];
				line_rd_q  <= data_mem[i_rd_index];
				valid_rd_q <= valid_q[i_rd_index];
			end
		end

		// valid bits
		always_ff @(posedge clk or negedge i_rst_n) begin
			if (!i_rst_n) begin
				valid_q <= '0;   // whole cache empty
			end else if (sel && i_fill.invalidate) begin
				valid_q[i_fill.index] <= 1'b0;   // victim goes away at refill start
			end else if (sel && i_fill.line_we) begin
				valid_q[i_fill.index] <= 1'b1;
			end
		end

		assign o_tags[w]  = tag_rd_q;
		assign o_lines[w] = line_rd_q;
		assign o_valid[w] = valid_rd_q;

		// refill words only land in a line that was invalidated first
		a_fill_invalid : assert property (
			@(posedge clk) disable iff (!i_rst_n)
			(sel && i_fill.word_we) |-> !valid_q[i_fill.index]
		) else $error("refill word written into a valid line, way %0d", w);
	end

endmodule

`default_nettype wire

/* icache_if.sv */
`default_nettype none

// miss request from the lookup controller to the refill engine
interface miss_req_if;
	import icache_pkg::*;

	logic  start;      // one cycle, only while refill is idle
	addr_t line_addr;  // address that missed
	way_t  way;        // victim way
	logic  done;       // line complete, one cycle

	modport ctrl (output start, output line_addr, output way, input done);
	modport refill (input start, input line_addr, input way, output done);
endinterface

// refill write path into the way arrays
interface refill_if;
	import icache_pkg::*;

	logic      invalidate; // clear victim valid at refill start
	way_t      way;
	index_t    index;
	tag_t      tag;        // written with line_we
	word_sel_t word_sel;
	word_t     data;
	logic      word_we;    // one per bus word
	logic      line_we;    // after last word, tag + valid

	modport refill (
		output invalidate, output way, output index, output tag,
		output word_sel, output data, output word_we, output line_we
	);
	modport ways (
		input invalidate, input way, input index, input tag,
		input word_sel, input data, input word_we, input line_we
	);
endinterface

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

	// word and address width
	localparam int unsigned WORD_W      = 32;

	// cache geometry
	localparam int unsigned NUM_WAYS    = 4;
	localparam int unsigned NUM_SETS    = 256;
	localparam int unsigned LINE_WORDS  = 16;   // words per line
	localparam int unsigned GROUP_WORDS = 4;    // words handed to fetch at once

	// address field positions, derived from the geometry
	localparam int unsigned WORD_LSB    = 2;    // 4 bytes per word
	localparam int unsigned GROUP_LSB   = WORD_LSB + $clog2(GROUP_WORDS);   // 4
	localparam int unsigned INDEX_LSB   = WORD_LSB + $clog2(LINE_WORDS);    // 6
	localparam int unsigned TAG_LSB     = INDEX_LSB + $clog2(NUM_SETS);     // 14

	typedef logic [WORD_W-1:0]                         addr_t;      // byte address
	typedef logic [WORD_W-1:0]                         word_t;      // one bus word
	typedef logic [GROUP_WORDS*WORD_W-1:0]             group_t;     // four words to fetch
	typedef logic [LINE_WORDS*WORD_W-1:0]              line_t;      // whole 16 word line
	typedef logic [WORD_W-TAG_LSB-1:0]                 tag_t;       // addr 31:14
	typedef logic [$clog2(NUM_SETS)-1:0]               index_t;     // addr 13:6
	typedef logic [$clog2(LINE_WORDS)-1:0]             word_sel_t;  // word inside line
	typedef logic [$clog2(LINE_WORDS/GROUP_WORDS)-1:0] group_sel_t; // addr 5:4
	typedef logic [$clog2(NUM_WAYS)-1:0]               way_t;
	typedef logic [NUM_WAYS-2:0]                       plru_t;      // tree bits of one set

	// lookup controller states
	typedef enum logic [1:0] {
		IDLE,   // waiting for a fetch request
		LOOKUP, // array read and tag compare
		MISS    // line refill in progress
	} ctrl_state_t;

endpackage

`default_nettype wire
